//--- common/icache_defines.svh
`ifndef ICACHE_DEFINES_SVH
`define ICACHE_DEFINES_SVH

// byte address and word widths
`define ICACHE_ADDR_W 32
`define ICACHE_WORD_W 32

// line geometry, 16 words of 32 bits
`define ICACHE_LINE_WORDS 16
`define ICACHE_LINE_W 512

// address split: tag | index | word | byte
`define ICACHE_OFFSET_W 6
`define ICACHE_WORD_SEL_W 4
`define ICACHE_INDEX_W 5
`define ICACHE_TAG_W 21

// sets per way
`define ICACHE_SETS 32

`endif

//--- common/icache_pkg.sv
package icache_pkg;

   // request FSM
   typedef enum logic [1:0] {
      st_idle    = 2'd0,
      st_lookup  = 2'd1,
      st_refill  = 2'd2,
      st_respond = 2'd3
   } icache_state_t;

   // cacop_mod encodings
   // code 3 decodes as op_index_inv
   typedef enum logic [1:0] {
      op_store_tag = 2'd0,
      op_index_inv = 2'd1,
      op_hit_inv   = 2'd2
   } cacop_op_t;

endpackage

//--- icache/icache_ram.sv
`timescale 1ns/10ps
`include "icache_defines.svh"

module icache_ram #(
   parameter int WIDTH = `ICACHE_TAG_W
) (
   input  logic                       clk,
   input  logic [`ICACHE_INDEX_W-1:0] index,
   input  logic                       wr_en,
   input  logic [WIDTH-1:0]           wr_data,
   output logic [WIDTH-1:0]           rd_data
);

   // one entry per set
   logic [WIDTH-1:0] mem [`ICACHE_SETS];

   always_ff @(posedge clk) begin
      if (wr_en) begin
         mem[index] <= wr_data;
      end
   end

   // read is combinational, same cycle as lookup
   assign rd_data = mem[index];

   // a write to an unknown set would corrupt an arbitrary line
   a_index_known: assert property (@(posedge clk) wr_en |-> !$isunknown(index))
      else $error("icache_ram write with unknown index");

endmodule

//--- icache/icache_lookup.sv
`timescale 1ns/10ps
`include "icache_defines.svh"

module icache_lookup (
   input  logic [`ICACHE_TAG_W-1:0]      lookup_tag,
   input  logic [`ICACHE_WORD_SEL_W-1:0] word_sel,
   input  logic [`ICACHE_TAG_W-1:0]      way0_tag,
   input  logic [`ICACHE_TAG_W-1:0]      way1_tag,
   input  logic                          way0_valid,
   input  logic                          way1_valid,
   input  logic [`ICACHE_LINE_W-1:0]     way0_line,
   input  logic [`ICACHE_LINE_W-1:0]     way1_line,
   output logic                          hit,
   output logic                          hit_way,
   output logic [`ICACHE_WORD_W-1:0]     hit_word
);

   logic way0_hit;
   logic way1_hit;
   logic [`ICACHE_LINE_W-1:0] sel_line;

   // tag match only counts on a valid way
   assign way0_hit = way0_valid && (way0_tag == lookup_tag);
   assign way1_hit = way1_valid && (way1_tag == lookup_tag);

   assign hit     = way0_hit || way1_hit;
   assign hit_way = way1_hit;

   // pick the line of the hitting way, then the addressed word
   assign sel_line = hit_way ? way1_line : way0_line;
   assign hit_word = sel_line[word_sel*`ICACHE_WORD_W +: `ICACHE_WORD_W];

   // a refill only happens on a miss, so one tag is never held in both ways
   always_comb begin
      a_one_way_hit: assert #0 ($isunknown({way0_hit, way1_hit}) || !(way0_hit && way1_hit))
         else $error("icache_lookup hit in both ways");
   end

endmodule

//--- icache/icache_refill.sv
`timescale 1ns/10ps
`include "icache_defines.svh"

module icache_refill
   import icache_pkg::*;
(
   input  logic                      clk,
   input  logic                      reset,
   input  icache_state_t             state,
   input  logic [`ICACHE_ADDR_W-1:0] req_addr,
   input  logic [`ICACHE_WORD_W-1:0] mem_rdata,
   input  logic                      mem_rdata_valid,
   output logic                      line_full,
   output logic [`ICACHE_LINE_W-1:0] refill_line,
   output logic [`ICACHE_ADDR_W-1:0] mem_addr,
   output logic                      mem_ce
);

   // counts 0..16, one extra bit for the full count
   logic [`ICACHE_WORD_SEL_W:0] beat_cnt;
   logic                        beat;

   assign line_full = (beat_cnt == `ICACHE_LINE_WORDS);
   assign beat      = (state == st_refill) && mem_rdata_valid && !line_full;

   always_ff @(posedge clk) begin
      if (reset) begin
         beat_cnt <= '0;
      end else if (state == st_idle) begin
         // previous line was consumed in st_respond
         beat_cnt <= '0;
      end else if (beat) begin
         beat_cnt <= beat_cnt + 1'b1;
      end
   end

   // new word enters at the top, so word 0 ends up lowest
   always_ff @(posedge clk) begin
      if (beat) begin
         refill_line <= {mem_rdata, refill_line[`ICACHE_LINE_W-1:`ICACHE_WORD_W]};
      end
   end

   // line aligned fetch address
   assign mem_addr = {req_addr[`ICACHE_ADDR_W-1:`ICACHE_OFFSET_W], {`ICACHE_OFFSET_W{1'b0}}};

   // held for the whole refill, dropped once 16 beats are in
   assign mem_ce = (state == st_refill) && !line_full;

   // memory must not return data that was not requested
   a_no_stray_beat: assert property (
      @(posedge clk) disable iff (reset) mem_rdata_valid |-> mem_ce)
      else $error("icache_refill mem_rdata_valid while mem_ce low");

endmodule

//--- icache/icache_ctrl.sv
`timescale 1ns/10ps
`include "icache_defines.svh"

module icache_ctrl
   import icache_pkg::*;
(
   input  logic                       clk,
   input  logic                       reset,
   input  logic                       ce,
   input  logic [`ICACHE_ADDR_W-1:0]  addr,
   input  logic                       cacop_en,
   input  logic [1:0]                 cacop_mod,
   input  logic [`ICACHE_ADDR_W-1:0]  cacop_va,
   input  logic                       rdata_ready,
   input  logic                       hit,
   input  logic                       hit_way,
   input  logic [`ICACHE_WORD_W-1:0]  hit_word,
   input  logic                       line_full,
   input  logic [`ICACHE_LINE_W-1:0]  refill_line,
   output icache_state_t              state,
   output logic [`ICACHE_ADDR_W-1:0]  req_addr,
   output logic [`ICACHE_INDEX_W-1:0] index,
   output logic                       way0_valid,
   output logic                       way1_valid,
   output logic                       way0_wr_en,
   output logic                       way1_wr_en,
   output logic [`ICACHE_TAG_W-1:0]   wr_tag,
   output logic [`ICACHE_WORD_W-1:0]  rdata,
   output logic                       rdata_valid,
   output logic                       cacop_finish,
   output logic                       busy
);

   logic                     is_cacop;
   cacop_op_t                op_q;
   logic [`ICACHE_SETS-1:0]  valid0;
   logic [`ICACHE_SETS-1:0]  valid1;
   logic [`ICACHE_SETS-1:0]  lru_bits;
   logic                     victim;
   logic                     read_hit;
   logic                     fill;
   logic                     cacop_we;
   logic                     cacop_way;
   logic [`ICACHE_WORD_SEL_W-1:0] word_sel;

   always_ff @(posedge clk) begin
      if (reset) begin
         state    <= st_idle;
         is_cacop <= 1'b0;
      end else begin
         case (state)
            st_idle: begin
               // cache ops win over reads
               if (cacop_en || ce) begin
                  state    <= st_lookup;
                  is_cacop <= cacop_en;
               end
            end
            st_lookup: begin
               if (is_cacop) begin
                  state <= st_idle;
               end else if (hit) begin
                  if (rdata_ready) state <= st_idle;
               end else begin
                  state <= st_refill;
               end
            end
            st_refill: begin
               if (line_full) state <= st_respond;
            end
            default: begin
               if (rdata_ready) state <= st_idle;
            end
         endcase
      end
   end

   // request held so the cpu may move on after acceptance
   always_ff @(posedge clk) begin
      if (state == st_idle) begin
         if (cacop_en) begin
            req_addr <= cacop_va;
            case (cacop_mod)
               2'd0:    op_q <= op_store_tag;
               2'd2:    op_q <= op_hit_inv;
               default: op_q <= op_index_inv;
            endcase
         end else if (ce) begin
            req_addr <= addr;
         end
      end
   end

   assign index    = req_addr[`ICACHE_OFFSET_W +: `ICACHE_INDEX_W];
   assign word_sel = req_addr[2 +: `ICACHE_WORD_SEL_W];

   assign way0_valid = valid0[index];
   assign way1_valid = valid1[index];
   assign victim     = lru_bits[index];

   assign read_hit = (state == st_lookup) && !is_cacop && hit;
   assign fill     = (state == st_refill) && line_full;

   // hit invalidate on a miss has nothing to clear
   assign cacop_we  = (state == st_lookup) && is_cacop && ((op_q != op_hit_inv) || hit);
   assign cacop_way = (op_q == op_hit_inv) ? hit_way : req_addr[0];

   always_ff @(posedge clk) begin
      if (reset) begin
         valid0   <= '0;
         valid1   <= '0;
         lru_bits <= '0;
      end else begin
         if (fill) begin
            if (victim) valid1[index] <= 1'b1;
            else valid0[index] <= 1'b1;
            lru_bits[index] <= ~victim;
         end
         if (cacop_we) begin
            if (cacop_way) valid1[index] <= 1'b0;
            else valid0[index] <= 1'b0;
         end
         // lru points at the way that was not used
         if (read_hit) begin
            lru_bits[index] <= ~hit_way;
         end
      end
   end

   assign way0_wr_en = (fill && !victim) || (cacop_we && !cacop_way);
   assign way1_wr_en = (fill && victim) || (cacop_we && cacop_way);

   assign wr_tag = (is_cacop && (op_q == op_store_tag)) ? '0 :
                   req_addr[`ICACHE_ADDR_W-1 -: `ICACHE_TAG_W];

   assign rdata = (state == st_respond) ?
                  refill_line[word_sel*`ICACHE_WORD_W +: `ICACHE_WORD_W] : hit_word;

   assign rdata_valid  = read_hit || (state == st_respond);
   assign cacop_finish = (state == st_lookup) && is_cacop;
   assign busy         = (state != st_idle);

   a_valid_excl: assert property (
      @(posedge clk) disable iff (reset) !(rdata_valid && cacop_finish))
      else $error("icache_ctrl rdata_valid with cacop_finish");

endmodule

//--- icache/icache_top.sv
`timescale 1ns/10ps
`include "icache_defines.svh"

module icache_top
   import icache_pkg::*;
(
   input  logic                      clk,
   input  logic                      reset,
   input  logic                      ce,
   input  logic [`ICACHE_ADDR_W-1:0] addr,
   input  logic                      cacop_en,
   input  logic [1:0]                cacop_mod,
   input  logic [`ICACHE_ADDR_W-1:0] cacop_va,
   input  logic                      rdata_ready,
   output logic [`ICACHE_WORD_W-1:0] rdata,
   output logic                      rdata_valid,
   output logic                      cacop_finish,
   output logic                      busy,
   output logic [`ICACHE_ADDR_W-1:0] mem_addr,
   output logic                      mem_ce,
   input  logic [`ICACHE_WORD_W-1:0] mem_rdata,
   input  logic                      mem_rdata_valid
);

   icache_state_t              state;
   logic [`ICACHE_ADDR_W-1:0]  req_addr;
   logic [`ICACHE_INDEX_W-1:0] index;
   logic                       way0_valid;
   logic                       way1_valid;
   logic                       way0_wr_en;
   logic                       way1_wr_en;
   logic [`ICACHE_TAG_W-1:0]   wr_tag;
   logic [`ICACHE_TAG_W-1:0]   way0_tag;
   logic [`ICACHE_TAG_W-1:0]   way1_tag;
   logic [`ICACHE_LINE_W-1:0]  way0_line;
   logic [`ICACHE_LINE_W-1:0]  way1_line;
   logic [`ICACHE_LINE_W-1:0]  refill_line;
   logic                       hit;
   logic                       hit_way;
   logic [`ICACHE_WORD_W-1:0]  hit_word;
   logic                       line_full;

   // tag arrays
   icache_ram #(.WIDTH(`ICACHE_TAG_W)) u_tag_way0 (
      .clk(clk), .index(index), .wr_en(way0_wr_en), .wr_data(wr_tag), .rd_data(way0_tag)
   );
   icache_ram #(.WIDTH(`ICACHE_TAG_W)) u_tag_way1 (
      .clk(clk), .index(index), .wr_en(way1_wr_en), .wr_data(wr_tag), .rd_data(way1_tag)
   );

   // data arrays take the whole refilled line
   icache_ram #(.WIDTH(`ICACHE_LINE_W)) u_data_way0 (
      .clk(clk), .index(index), .wr_en(way0_wr_en), .wr_data(refill_line), .rd_data(way0_line)
   );
   icache_ram #(.WIDTH(`ICACHE_LINE_W)) u_data_way1 (
      .clk(clk), .index(index), .wr_en(way1_wr_en), .wr_data(refill_line), .rd_data(way1_line)
   );

   icache_lookup u_lookup (
      .lookup_tag(req_addr[`ICACHE_ADDR_W-1 -: `ICACHE_TAG_W]),
      .word_sel(req_addr[2 +: `ICACHE_WORD_SEL_W]),
      .way0_tag(way0_tag), .way1_tag(way1_tag),
      .way0_valid(way0_valid), .way1_valid(way1_valid),
      .way0_line(way0_line), .way1_line(way1_line),
      .hit(hit), .hit_way(hit_way), .hit_word(hit_word)
   );

   icache_refill u_refill (
      .clk(clk), .reset(reset), .state(state), .req_addr(req_addr),
      .mem_rdata(mem_rdata), .mem_rdata_valid(mem_rdata_valid),
      .line_full(line_full), .refill_line(refill_line),
      .mem_addr(mem_addr), .mem_ce(mem_ce)
   );

   icache_ctrl u_ctrl (
      .clk(clk), .reset(reset), .ce(ce), .addr(addr),
      .cacop_en(cacop_en), .cacop_mod(cacop_mod), .cacop_va(cacop_va),
      .rdata_ready(rdata_ready), .hit(hit), .hit_way(hit_way), .hit_word(hit_word),
      .line_full(line_full), .refill_line(refill_line),
      .state(state), .req_addr(req_addr), .index(index),
      .way0_valid(way0_valid), .way1_valid(way1_valid),
      .way0_wr_en(way0_wr_en), .way1_wr_en(way1_wr_en), .wr_tag(wr_tag),
      .rdata(rdata), .rdata_valid(rdata_valid), .cacop_finish(cacop_finish), .busy(busy)
   );

endmodule

//--- verification/icache_mem_model.sv
`timescale 1ns/10ps
`include "icache_defines.svh"

module icache_mem_model (
   input  logic                      clk,
   input  logic                      reset,
   input  logic                      mem_ce,
   input  logic [`ICACHE_ADDR_W-1:0] mem_addr,
   output logic [`ICACHE_WORD_W-1:0] mem_rdata,
   output logic                      mem_rdata_valid
);

   integer seed = 32'hcfc5;
   int     gap;
   int     beat;

   // one line per refill, lowest word first, random idle gaps between words
   initial begin
      mem_rdata       = '0;
      mem_rdata_valid = 1'b0;
      forever begin
         @(posedge clk);
         #1;
         if (mem_ce && !reset) begin
            for (beat = 0; beat < `ICACHE_LINE_WORDS; beat++) begin
               gap = $random(seed) & 3;
               repeat (gap) begin
                  @(posedge clk);
                  #1;
               end
               // word at byte address A reads as A xor 5a5a0000
               mem_rdata       = (mem_addr + 32'(beat * 4)) ^ 32'h5a5a_0000;
               mem_rdata_valid = 1'b1;
               @(posedge clk);
               #1;
               mem_rdata_valid = 1'b0;
            end
         end
      end
   end

endmodule

//--- verification/icache_tb.sv
`timescale 1ns/10ps
`include "icache_defines.svh"

module icache_tb
   import icache_pkg::*;
();

   localparam int NUM_STEPS  = 17;
   localparam int WAIT_LIMIT = 200;

   typedef enum logic {k_read, k_cacop} step_kind_t;

   typedef struct packed {
      step_kind_t                kind;
      logic [`ICACHE_ADDR_W-1:0] addr;
      logic [1:0]                mode;
      logic                      miss;
      logic [3:0]                stall;
   } step_t;

   logic                      clk;
   logic                      reset;
   logic                      ce;
   logic [`ICACHE_ADDR_W-1:0] addr;
   logic                      cacop_en;
   logic [1:0]                cacop_mod;
   logic [`ICACHE_ADDR_W-1:0] cacop_va;
   logic                      rdata_ready;
   logic [`ICACHE_WORD_W-1:0] rdata;
   logic                      rdata_valid;
   logic                      cacop_finish;
   logic                      busy;
   logic [`ICACHE_ADDR_W-1:0] mem_addr;
   logic                      mem_ce;
   logic [`ICACHE_WORD_W-1:0] mem_rdata;
   logic                      mem_rdata_valid;

   // set 3 holds tags A=10c0, B=20c0, C=30c0; set 4 holds line 0100
   // miss column is filled by predict_step before the run
   step_t steps [NUM_STEPS] = '{
      '{k_read,  32'h0000_0104, 2'd0, 1'b0, 4'd0},
      '{k_read,  32'h0000_0138, 2'd0, 1'b0, 4'd0},
      '{k_read,  32'h0000_10c8, 2'd0, 1'b0, 4'd0},
      '{k_read,  32'h0000_20d0, 2'd0, 1'b0, 4'd0},
      '{k_read,  32'h0000_10fc, 2'd0, 1'b0, 4'd3},
      '{k_read,  32'h0000_30c4, 2'd0, 1'b0, 4'd4},
      '{k_read,  32'h0000_10c0, 2'd0, 1'b0, 4'd0},
      '{k_read,  32'h0000_20c0, 2'd0, 1'b0, 4'd0},
      '{k_cacop, 32'h0000_10c0, 2'd1, 1'b0, 4'd0},
      '{k_read,  32'h0000_10c4, 2'd0, 1'b0, 4'd0},
      '{k_cacop, 32'h0000_20c0, 2'd2, 1'b0, 4'd0},
      '{k_read,  32'h0000_20c8, 2'd0, 1'b0, 4'd0},
      '{k_cacop, 32'h0000_10c0, 2'd0, 1'b0, 4'd0},
      '{k_read,  32'h0000_10cc, 2'd0, 1'b0, 4'd1},
      '{k_read,  32'h0000_0100, 2'd0, 1'b0, 4'd2},
      '{k_cacop, 32'h0000_0100, 2'd3, 1'b0, 4'd0},
      '{k_read,  32'h0000_0108, 2'd0, 1'b0, 4'd0}
   };

   // reference valid/tag/lru state
   logic [`ICACHE_SETS-1:0]  ref_valid0;
   logic [`ICACHE_SETS-1:0]  ref_valid1;
   logic [`ICACHE_SETS-1:0]  ref_lru;
   logic [`ICACHE_TAG_W-1:0] ref_tag0 [`ICACHE_SETS];
   logic [`ICACHE_TAG_W-1:0] ref_tag1 [`ICACHE_SETS];

   icache_top u_icache_top (
      .clk(clk), .reset(reset), .ce(ce), .addr(addr),
      .cacop_en(cacop_en), .cacop_mod(cacop_mod), .cacop_va(cacop_va),
      .rdata_ready(rdata_ready), .rdata(rdata), .rdata_valid(rdata_valid),
      .cacop_finish(cacop_finish), .busy(busy), .mem_addr(mem_addr), .mem_ce(mem_ce),
      .mem_rdata(mem_rdata), .mem_rdata_valid(mem_rdata_valid)
   );

   icache_mem_model u_mem_model (
      .clk(clk), .reset(reset), .mem_ce(mem_ce), .mem_addr(mem_addr),
      .mem_rdata(mem_rdata), .mem_rdata_valid(mem_rdata_valid)
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   task automatic fail_run(input string why);
      $display("%s", why);
      $display("Test failed");
      $fatal(1, "simulation stopped at %0t", $time);
   endtask

   task automatic check_word(input string name, input logic [`ICACHE_WORD_W-1:0] got,
                             input logic [`ICACHE_WORD_W-1:0] exp);
      if (got !== exp) begin
         fail_run($sformatf("[ERROR] %s got 0x%h expected 0x%h", name, got, exp));
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         fail_run($sformatf("[ERROR] %s got 0x%h expected 0x%h", name, got, exp));
      end
   endtask

   task automatic check_state_idle(input icache_state_t got);
      if (got !== st_idle) begin
         fail_run($sformatf("[ERROR] state got 0x%h expected 0x%h", got, st_idle));
      end
   endtask

   function automatic logic [`ICACHE_WORD_W-1:0] rule_word(
      input logic [`ICACHE_ADDR_W-1:0] a);
      return {a[`ICACHE_ADDR_W-1:2], 2'b00} ^ 32'h5a5a_0000;
   endfunction

   // start of the 64-byte line holding a
   function automatic logic [`ICACHE_ADDR_W-1:0] line_base(
      input logic [`ICACHE_ADDR_W-1:0] a);
      return a & ~(32'(`ICACHE_LINE_WORDS * 4) - 32'd1);
   endfunction

   // two ways, one lru bit per set naming the next victim
   task automatic predict_step(input int i);
      logic [`ICACHE_INDEX_W-1:0] set;
      logic [`ICACHE_TAG_W-1:0]   tag;
      logic                       hit0;
      logic                       hit1;
      logic                       way;
      set  = steps[i].addr[`ICACHE_OFFSET_W +: `ICACHE_INDEX_W];
      tag  = steps[i].addr[`ICACHE_ADDR_W-1 -: `ICACHE_TAG_W];
      hit0 = ref_valid0[set] && (ref_tag0[set] == tag);
      hit1 = ref_valid1[set] && (ref_tag1[set] == tag);
      if (steps[i].kind == k_read) begin
         steps[i].miss = !(hit0 || hit1);
         way = (hit0 || hit1) ? hit1 : ref_lru[set];
         if (way) begin
            ref_valid1[set] = 1'b1;
            ref_tag1[set]   = tag;
         end else begin
            ref_valid0[set] = 1'b1;
            ref_tag0[set]   = tag;
         end
         ref_lru[set] = ~way;
      end else if (steps[i].mode == 2'd2) begin
         // hit invalidate only clears a resident line
         if (hit0) ref_valid0[set] = 1'b0;
         if (hit1) ref_valid1[set] = 1'b0;
      end else if (steps[i].addr[0]) begin
         ref_valid1[set] = 1'b0;
      end else begin
         ref_valid0[set] = 1'b0;
      end
   endtask

   task automatic run_step(input int i);
      step_t                     s;
      logic                      saw_ce;
      logic [`ICACHE_WORD_W-1:0] first;
      int                        cycles;
      int                        k;
      s      = steps[i];
      saw_ce = 1'b0;
      cycles = 0;
      @(posedge clk);
      #1;
      if (s.kind == k_cacop) begin
         cacop_en  = 1'b1;
         cacop_mod = s.mode;
         cacop_va  = s.addr;
      end else begin
         ce          = 1'b1;
         addr        = s.addr;
         rdata_ready = (s.stall == 4'd0);
      end
      @(posedge clk);
      #1;
      // request is latched at acceptance
      ce       = 1'b0;
      cacop_en = 1'b0;
      addr     = ~s.addr;
      cacop_va = ~s.addr;
      @(negedge clk);
      check_bit("busy", busy, 1'b1);
      if (s.kind == k_cacop) begin
         while (!cacop_finish) begin
            cycles++;
            if (cycles > WAIT_LIMIT) fail_run($sformatf("no cacop_finish in step %0d", i));
            @(negedge clk);
         end
         check_bit("mem_ce", mem_ce, 1'b0);
         @(negedge clk);
         check_bit("cacop_finish", cacop_finish, 1'b0);
      end else begin
         while (!rdata_valid) begin
            if (mem_ce) begin
               saw_ce = 1'b1;
               check_word("mem_addr", mem_addr, line_base(s.addr));
            end
            cycles++;
            if (cycles > WAIT_LIMIT) fail_run($sformatf("no rdata_valid in step %0d", i));
            @(negedge clk);
         end
         check_bit("mem_ce", saw_ce, s.miss);
         check_bit("mem_ce", mem_ce, 1'b0);
         check_word("rdata", rdata, rule_word(s.addr));
         first = rdata;
         // response must hold while rdata_ready is low
         for (k = 1; k <= int'(s.stall); k++) begin
            @(posedge clk);
            #1;
            rdata_ready = (k == int'(s.stall));
            @(negedge clk);
            check_bit("rdata_valid", rdata_valid, 1'b1);
            check_word("rdata", rdata, first);
            check_bit("mem_ce", mem_ce, 1'b0);
         end
         @(posedge clk);
         #1;
         rdata_ready = 1'b0;
         @(negedge clk);
      end
      check_state_idle(u_icache_top.state);
      check_bit("busy", busy, 1'b0);
   endtask

   initial begin
      int i;
      reset       = 1'b1;
      ce          = 1'b0;
      addr        = '0;
      cacop_en    = 1'b0;
      cacop_mod   = '0;
      cacop_va    = '0;
      rdata_ready = 1'b0;
      ref_valid0  = '0;
      ref_valid1  = '0;
      ref_lru     = '0;
      for (i = 0; i < NUM_STEPS; i++) begin
         predict_step(i);
      end
      repeat (10) @(posedge clk);
      #1;
      reset = 1'b0;
      @(negedge clk);
      check_bit("busy", busy, 1'b0);
      check_bit("mem_ce", mem_ce, 1'b0);
      check_bit("rdata_valid", rdata_valid, 1'b0);
      check_bit("cacop_finish", cacop_finish, 1'b0);
      for (i = 0; i < NUM_STEPS; i++) begin
         run_step(i);
      end
      $display("Test completed successfully");
      $finish;
   end

endmodule

//--- flist.f
+incdir+common
common/icache_pkg.sv
icache/icache_ram.sv
icache/icache_lookup.sv
icache/icache_refill.sv
icache/icache_ctrl.sv
icache/icache_top.sv
verification/icache_mem_model.sv
verification/icache_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the icache testbench, pass only when the log holds the pass line
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --timescale 1ns/10ps -f flist.f \
   --top-module icache_tb -o icache_sim &&
   ./obj_dir/icache_sim > sim.log 2>&1
grep -q "Test completed successfully" sim.log && echo "PASS" && exit 0 ||
   { echo "FAIL, see sim.log"; exit 1; }
